//--- rtl/lsu_pkg.sv
package lsu_pkg;

    localparam int DATA_W    = 32;
    localparam int ADDR_W    = 32;
    localparam int RAM_IDX_W = 10; // 1024 words, 4 KB window
    localparam int UPPER_W   = ADDR_W - RAM_IDX_W - 2;

    // funct3 encodings of the load/store width
    typedef enum logic [2:0] {
        LSU_B  = 3'b000,
        LSU_H  = 3'b001,
        LSU_W  = 3'b010,
        LSU_BU = 3'b100,
        LSU_HU = 3'b101
    } lsu_size_e;

    typedef struct packed {
        logic [UPPER_W-1:0]   upper;    // ignored by the memory, so accesses wrap
        logic [RAM_IDX_W-1:0] word_idx;
        logic [1:0]           byte_off;
    } lsu_addr_fields_t;

    typedef union packed {
        logic [ADDR_W-1:0] raw;
        lsu_addr_fields_t  fields;
    } lsu_addr_u;

    typedef struct packed {
        logic              rd;
        logic              wr;
        lsu_size_e         size;
        lsu_addr_u         addr;
        logic [DATA_W-1:0] wdata;
    } lsu_req_t;

    typedef struct packed {
        logic                 we;
        logic [3:0]           be;
        logic [RAM_IDX_W-1:0] idx;
        logic [DATA_W-1:0]    data;
    } ram_wr_t;

    typedef struct packed {
        logic [1:0] byte_off;
        lsu_size_e  size;
        logic       ok;   // legal size and aligned
    } lane_sel_t;

endpackage

//--- rtl/lsu_ctrl.sv
`timescale 1ns/1ns

module lsu_ctrl (
    input  logic                      clk,
    input  logic                      rst_n,
    input  lsu_pkg::lsu_req_t         req,
    output lsu_pkg::lane_sel_t        sel,
    output logic [3:0]                be,
    output logic                      fault,
    output logic [lsu_pkg::ADDR_W-1:0] fault_addr,
    output logic                      fault_valid
);

    logic [1:0] byte_off;
    logic [3:0] lane_be;
    logic       ok;

    assign byte_off = req.addr.fields.byte_off;

    always_comb begin
        lane_be = 4'b0000;
        ok      = 1'b0;
        case (req.size)
            lsu_pkg::LSU_B, lsu_pkg::LSU_BU: begin
                lane_be = 4'b0001;
                ok      = 1'b1; // any offset is fine for a byte
            end
            lsu_pkg::LSU_H, lsu_pkg::LSU_HU: begin
                lane_be = 4'b0011;
                ok      = ~byte_off[0];
            end
            lsu_pkg::LSU_W: begin
                lane_be = 4'b1111;
                ok      = (byte_off == 2'b00);
            end
            default: begin
                lane_be = 4'b0000;
                ok      = 1'b0; // undefined funct3
            end
        endcase
    end

    assign be    = ok ? (lane_be << byte_off) : 4'b0000;
    assign fault = (req.rd | req.wr) & ~ok;

    assign sel.byte_off = byte_off;
    assign sel.size     = req.size;
    assign sel.ok       = ok;

    // sticky record of the latest faulting access
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fault_addr  <= '0;
            fault_valid <= 1'b0;
        end else if (fault) begin
            fault_addr  <= req.addr.raw;
            fault_valid <= 1'b1;
        end
    end

endmodule

//--- rtl/store_align.sv
`timescale 1ns/1ns

module store_align (
    input  lsu_pkg::lsu_req_t  req,
    input  lsu_pkg::lane_sel_t sel,
    input  logic [3:0]         be,
    output lsu_pkg::ram_wr_t   wr_rec
);

    logic [lsu_pkg::DATA_W-1:0] lane_data;

    // low byte/half copied into every lane so be picks the one that lands
    always_comb begin
        case (sel.size)
            lsu_pkg::LSU_B, lsu_pkg::LSU_BU: lane_data = {4{req.wdata[7:0]}};
            lsu_pkg::LSU_H, lsu_pkg::LSU_HU: lane_data = {2{req.wdata[15:0]}};
            default:                         lane_data = req.wdata;
        endcase
    end

    // unsigned codes store like sb/sh
    assign wr_rec.we   = req.wr & sel.ok;
    assign wr_rec.be   = be;
    assign wr_rec.idx  = req.addr.fields.word_idx;
    assign wr_rec.data = lane_data;

endmodule

//--- rtl/data_ram.sv
`timescale 1ns/1ns

module data_ram (
    input  logic                          clk,
    input  lsu_pkg::ram_wr_t              wr_rec,
    input  logic [lsu_pkg::RAM_IDX_W-1:0] rd_idx,
    output logic [lsu_pkg::DATA_W-1:0]    rd_word
);

    localparam int DEPTH = 2 ** lsu_pkg::RAM_IDX_W;
    localparam int NB    = lsu_pkg::DATA_W / 8;

    logic [lsu_pkg::DATA_W-1:0] mem [DEPTH];

    // per-byte write, old bytes stay in place
    always_ff @(posedge clk) begin
        if (wr_rec.we) begin
            for (int i = 0; i < NB; i++) begin
                if (wr_rec.be[i]) begin
                    mem[wr_rec.idx][8*i +: 8] <= wr_rec.data[8*i +: 8];
                end
            end
        end
    end

    assign rd_word = mem[rd_idx]; // async read, sees old word on read+write

    a_we_has_be : assert property (
        @(posedge clk) wr_rec.we |-> (wr_rec.be != 4'b0000)
    ) else $error("write strobe without byte enables");

endmodule

//--- rtl/load_extend.sv
`timescale 1ns/1ns

module load_extend (
    input  logic                       rd,
    input  logic [lsu_pkg::DATA_W-1:0] rd_word,
    input  lsu_pkg::lane_sel_t         sel,
    output logic [lsu_pkg::DATA_W-1:0] rdata
);

    logic [lsu_pkg::DATA_W-1:0] lane;

    assign lane = rd_word >> {sel.byte_off, 3'b000}; // addressed byte to bit 0

    always_comb begin
        rdata = '0;
        if (rd && sel.ok) begin
            case (sel.size)
                lsu_pkg::LSU_B:  rdata = {{24{lane[7]}}, lane[7:0]};
                lsu_pkg::LSU_H:  rdata = {{16{lane[15]}}, lane[15:0]};
                lsu_pkg::LSU_W:  rdata = lane;
                lsu_pkg::LSU_BU: rdata = {24'd0, lane[7:0]};
                lsu_pkg::LSU_HU: rdata = {16'd0, lane[15:0]};
                default:         rdata = '0;
            endcase
        end
    end

endmodule

//--- rtl/lsu_top.sv
`timescale 1ns/1ns

module lsu_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  lsu_pkg::lsu_req_t          req,
    output logic [lsu_pkg::DATA_W-1:0] rdata,
    output logic                       fault,
    output logic [lsu_pkg::ADDR_W-1:0] fault_addr,
    output logic                       fault_valid
);

    lsu_pkg::lane_sel_t         sel;
    logic [3:0]                 be;
    lsu_pkg::ram_wr_t           wr_rec;
    logic [lsu_pkg::DATA_W-1:0] rd_word;

    lsu_ctrl u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req),
        .sel         (sel),
        .be          (be),
        .fault       (fault),
        .fault_addr  (fault_addr),
        .fault_valid (fault_valid)
    );

    store_align u_store (
        .req    (req),
        .sel    (sel),
        .be     (be),
        .wr_rec (wr_rec)
    );

    data_ram u_ram (
        .clk     (clk),
        .wr_rec  (wr_rec),
        .rd_idx  (req.addr.fields.word_idx),
        .rd_word (rd_word)
    );

    load_extend u_load (
        .rd      (req.rd),
        .rd_word (rd_word),
        .sel     (sel),
        .rdata   (rdata)
    );

endmodule

//--- tb/lsu_checker.sv
`timescale 1ns/1ns

module lsu_checker (
    input  logic                       clk,
    input  logic                       rst_n,
    input  lsu_pkg::lsu_req_t          req,
    input  logic [lsu_pkg::DATA_W-1:0] rdata,
    input  logic                       fault,
    input  logic [lsu_pkg::ADDR_W-1:0] fault_addr,
    input  logic                       fault_valid,
    output int                         errors,
    output int                         checks
);

    logic [7:0]        mem_model [4096]; // byte image of the 4 KB window
    logic [31:0]       exp_faddr;
    logic              exp_fvalid;
    lsu_pkg::lsu_req_t held_req;         // request seen before the edge
    logic              held_ok;

    initial begin
        errors   = 0;
        checks   = 0;
        held_req = '0;
        held_ok  = 1'b0;
        for (int i = 0; i < 4096; i++) begin
            mem_model[i] = 8'h00;
        end
    end

    // access width in bytes, 0 for an undefined code
    function automatic int size_bytes(input lsu_pkg::lsu_size_e code);
        case (code)
            lsu_pkg::LSU_B, lsu_pkg::LSU_BU: return 1;
            lsu_pkg::LSU_H, lsu_pkg::LSU_HU: return 2;
            lsu_pkg::LSU_W:                  return 4;
            default:                         return 0;
        endcase
    endfunction

    function automatic logic access_ok(input lsu_pkg::lsu_req_t r);
        int n;
        n = size_bytes(r.size);
        return (n != 0) && ((int'(r.addr.raw[1:0]) % n) == 0);
    endfunction

    // little-endian gather from the byte image, then extend
    function automatic logic [31:0] model_load(input lsu_pkg::lsu_req_t r);
        logic [31:0] val;
        logic [11:0] a;
        int          n;
        val = '0;
        a   = r.addr.raw[11:0];
        n   = size_bytes(r.size);
        for (int k = 0; k < n; k++) begin
            val[8*k +: 8] = mem_model[a + k];
        end
        if (r.size == lsu_pkg::LSU_B && val[7]) val[31:8] = '1;
        if (r.size == lsu_pkg::LSU_H && val[15]) val[31:16] = '1;
        return val;
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error %s got %h expected %h at %0t ns", name, got, exp, $time);
        end
    endtask

    // mid-cycle, inputs and combinational outputs are settled
    always @(negedge clk) begin : sample
        logic        ok;
        logic [31:0] exp_rdata;
        ok        = access_ok(req);
        exp_rdata = (req.rd && ok) ? model_load(req) : 32'h0;
        compare("rdata", rdata, exp_rdata);
        compare("fault", {31'd0, fault}, {31'd0, (req.rd | req.wr) & ~ok});
        compare("fault_addr", fault_addr, exp_faddr);
        compare("fault_valid", {31'd0, fault_valid}, {31'd0, exp_fvalid});
        held_req = req;
        held_ok  = ok;
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exp_faddr  = '0;
            exp_fvalid = 1'b0;
        end else begin
            if (held_req.wr && held_ok) begin
                for (int k = 0; k < size_bytes(held_req.size); k++) begin
                    mem_model[held_req.addr.raw[11:0] + k] = held_req.wdata[8*k +: 8];
                end
            end
            if ((held_req.rd || held_req.wr) && !held_ok) begin
                exp_faddr  = held_req.addr.raw;
                exp_fvalid = 1'b1;
            end
        end
    end

endmodule

//--- tb/lsu_tb.sv
`timescale 1ns/1ns

module lsu_tb;

    localparam int N_FILL     = 1024;
    localparam int N_RAND     = 3000;
    localparam int RST_CYCLES = 16;
    localparam int TIMEOUT_NS = (N_FILL + N_RAND + RST_CYCLES + 20) * 4 * 2;

    logic                       clk = 1'b0;
    logic                       rst_n;
    lsu_pkg::lsu_req_t          req;
    logic [lsu_pkg::DATA_W-1:0] rdata;
    logic                       fault;
    logic [lsu_pkg::ADDR_W-1:0] fault_addr;
    logic                       fault_valid;
    int                         errors;
    int                         checks;
    logic [31:0]                lfsr_state;

    always #2 clk = ~clk; // 4 ns period

    lsu_top dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req),
        .rdata       (rdata),
        .fault       (fault),
        .fault_addr  (fault_addr),
        .fault_valid (fault_valid)
    );

    lsu_checker u_checker (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req),
        .rdata       (rdata),
        .fault       (fault),
        .fault_addr  (fault_addr),
        .fault_valid (fault_valid),
        .errors      (errors),
        .checks      (checks)
    );

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            val        = {val[30:0], lfsr_state[0]};
        end
    endtask

    task automatic send(input lsu_pkg::lsu_req_t r);
        @(posedge clk);
        req <= r;
    endtask

    task automatic build_random_req(output lsu_pkg::lsu_req_t r);
        logic [31:0] strobes;
        logic [31:0] code;
        logic [31:0] weight;
        logic [31:0] idx;
        logic [31:0] off;
        logic [31:0] upper;
        logic [31:0] data;
        draw_bits(2, strobes);
        if (strobes[1:0] == 2'b00) strobes = 32'd1; // plain read instead of idle
        draw_bits(3, code);
        draw_bits(2, weight);
        if (weight[1:0] != 2'b00 && (code[2:0] == 3'd3 || code[2:0] >= 3'd6)) begin
            code = code & 32'd5; // 3, 6, 7 fold onto h, bu, hu
        end
        draw_bits(6, idx);
        draw_bits(2, off);
        draw_bits(8, upper);
        draw_bits(32, data);
        r          = '0;
        r.rd       = strobes[0];
        r.wr       = strobes[1];
        r.size     = lsu_pkg::lsu_size_e'(code[2:0]);
        r.addr.raw = {12'd0, upper[7:0], 4'd0, idx[5:0], off[1:0]}; // upper bits test wrap
        r.wdata    = data;
    endtask

    initial begin : stimulus
        lsu_pkg::lsu_req_t r;
        logic [31:0]       data;
        lfsr_state = 32'hbceb;
        rst_n <= 1'b0;
        req   <= '0;
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < N_FILL; i++) begin
            draw_bits(32, data);
            r          = '0;
            r.wr       = 1'b1;
            r.size     = lsu_pkg::LSU_W;
            r.addr.raw = i * 4;
            r.wdata    = data;
            send(r);
        end
        for (int i = 0; i < N_RAND; i++) begin
            build_random_req(r);
            send(r);
        end
        send('0);
        repeat (2) @(posedge clk);
        $display("errors %0d, checks %0d", errors, checks);
        if (checks == 0) $display("no checks were made");
        if (errors == 0 && checks > 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("timeout: simulation did not finish within %0d ns", TIMEOUT_NS);
        $display(">>> FAIL");
        $finish;
    end

endmodule

//--- build.f
rtl/lsu_pkg.sv
rtl/lsu_ctrl.sv
rtl/store_align.sv
rtl/data_ram.sv
rtl/load_extend.sv
rtl/lsu_top.sv
tb/lsu_checker.sv
tb/lsu_tb.sv

//--- Bender.yml
package:
  name: lsu

sources:
  - rtl/lsu_pkg.sv
  - rtl/lsu_ctrl.sv
  - rtl/store_align.sv
  - rtl/data_ram.sv
  - rtl/load_extend.sv
  - rtl/lsu_top.sv
  - target: test
    files:
      - tb/lsu_checker.sv
      - tb/lsu_tb.sv
